/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module mul16_pipe_tb -f verilog.f -o mul16_pipe_sim
output=$(./obj_dir/mul16_pipe_sim +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'test passed'; then
  exit 0
fi
exit 1

/* verification/mul16_pipe_props.sv */
// Output handshake rules of mul16_pipe, bound into the top level and sampled on its clk
`default_nettype none

module mul16_pipe_props (
  input wire                       clk,
  input wire                       reset,
  input wire                       in_ready,
  input wire                       out_valid,
  input wire                       out_ready,
  input wire mul16_pkg::product_t  product
);

  int fail_count = 0;

  // A stalled result keeps its valid and value
  hold_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(product))
    else begin
      $error("result changed while the consumer stalled");
      fail_count++;
    end

  reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fail_count++;
    end

  // An empty output stage never blocks the input
  ready_when_empty: assert property (@(posedge clk) disable iff (reset)
    !out_valid |-> in_ready)
    else begin
      $error("in_ready low while out_valid is low");
      fail_count++;
    end

endmodule

bind mul16_pipe mul16_pipe_props u_props (
  .clk       (clk),
  .reset     (reset),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .product   (product)
);

`default_nettype wire

/* verification/mul16_pipe_tb.sv */
// Needs the bound mul16_pipe_props instance; Verilator timing mode, 40-unit clock, fixed seed 75
`default_nettype none

module mul16_pipe_tb;

  localparam int FIXED_COUNT = 10;
  localparam int TABLE_LEN = FIXED_COUNT + 16;
  localparam int RUN_LIMIT = 40 * (4 * TABLE_LEN + 50);

  // Directed corner cases ahead of the random entries
  localparam mul16_pkg::operand_t FIXED_A [FIXED_COUNT] = '{
    16'h0000, 16'h0000, 16'h0001, 16'hBEEF, 16'hFFFF,
    16'h00FF, 16'hFF00, 16'h1200, 16'h0012, 16'h8001};
  localparam mul16_pkg::operand_t FIXED_B [FIXED_COUNT] = '{
    16'h0000, 16'h1234, 16'hABCD, 16'h0001, 16'hFFFF,
    16'hFF00, 16'h00FF, 16'h3400, 16'h0034, 16'h7FFF};

  logic clk = 1'b0;
  logic reset;
  logic in_valid;
  logic in_ready;
  logic out_valid;
  logic out_ready;
  mul16_pkg::operand_t a;
  mul16_pkg::operand_t b;
  mul16_pkg::product_t product;

  mul16_pkg::operand_t tab_a [TABLE_LEN];
  mul16_pkg::operand_t tab_b [TABLE_LEN];
  mul16_pkg::product_t tab_exp [TABLE_LEN];

  // Scoreboard of pending results and their input edges
  mul16_pkg::product_t exp_q [$];
  int in_edge_q [$];

  int cur_index = 0;
  int cycle = 0;
  int reset_edges = 0;
  int error_count = 0;
  // 0 keeps out_ready high, 1 randomizes it, 2 holds it low
  int ready_mode = 0;

  always #20 clk = ~clk;

  mul16_pipe u_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .product   (product)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
    reset_edges <= reset ? reset_edges + 1 : 0;
  end

  always begin : ready_driver
    if (ready_mode == 1) begin
      out_ready = 1'($urandom % 2);
    end else begin
      out_ready = (ready_mode == 0);
    end
    @(posedge clk);
    #2;
  end

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // Handshakes settle before the falling edge and transfer on the next rising edge
  always @(negedge clk) begin : monitor
    int in_edge;
    if (reset) begin
      exp_q.delete();
      in_edge_q.delete();
      if (reset_edges > 0) begin
        check_equal("out_valid", 32'(out_valid), 32'd0);
        check_equal("in_ready", 32'(in_ready), 32'd1);
      end
    end else begin
      // Both stages full and the consumer stalled
      if (out_valid && !out_ready && exp_q.size() == 2) begin
        check_equal("in_ready", 32'(in_ready), 32'd0);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("unexpected result at %0t with no operation in flight", $time);
          error_count++;
        end else begin
          in_edge = in_edge_q.pop_front();
          check_equal("product", product, exp_q.pop_front());
          if (ready_mode == 0) begin
            check_equal("latency", 32'(cycle + 1 - in_edge), 32'd2);
          end
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(tab_exp[cur_index]);
        in_edge_q.push_back(cycle + 1);
      end
    end
  end

  task automatic pulse_reset(input int cycles);
    reset = 1'b1;
    repeat (cycles) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  task automatic set_ready_mode(input int mode);
    @(negedge clk);
    ready_mode = mode;
    @(posedge clk);
    #2;
  endtask

  task automatic apply_entries(input int first, input int count, input bit gaps);
    for (int i = first; i < first + count; i++) begin
      while (gaps && ($urandom % 3 == 0)) begin
        in_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      cur_index = i;
      a = tab_a[i];
      b = tab_b[i];
      in_valid = 1'b1;
      @(negedge clk);
      while (!in_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    #2;
  endtask

  initial begin : watchdog
    #(RUN_LIMIT);
    $display("timeout: the run did not finish within %0d time units", RUN_LIMIT);
    $display("test failed");
    $finish;
  end

  initial begin : stimulus
    int i;
    reset = 1'b1;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    void'($urandom(75));
    for (i = 0; i < TABLE_LEN; i++) begin
      if (i < FIXED_COUNT) begin
        tab_a[i] = FIXED_A[i];
        tab_b[i] = FIXED_B[i];
      end else begin
        tab_a[i] = 16'($urandom);
        tab_b[i] = 16'($urandom);
      end
      tab_exp[i] = 32'(tab_a[i]) * 32'(tab_b[i]);
    end
    pulse_reset(4);
    apply_entries(0, TABLE_LEN, 1'b0);
    wait_drain();
    // Fill both stages under a stalled consumer, then flush them
    set_ready_mode(2);
    apply_entries(0, 2, 1'b0);
    repeat (2) @(posedge clk);
    #2;
    pulse_reset(4);
    set_ready_mode(1);
    apply_entries(0, TABLE_LEN, 1'b1);
    wait_drain();
    set_ready_mode(0);
    repeat (4) @(posedge clk);
    #2;
    $display("errors: %0d in checks, %0d in assertions", error_count,
             u_dut.u_props.fail_count);
    if (error_count == 0 && u_dut.u_props.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/mul16_pkg.sv
verilog/mul8_array.sv
verilog/cla_adder.sv
verilog/partial_product_stage.sv
verilog/reduction_stage.sv
verilog/mul16_pipe.sv
verification/mul16_pipe_props.sv
verification/mul16_pipe_tb.sv

/* verilog/cla_adder.sv */
// 32-bit two-level carry-lookahead adder, carry-in fixed at zero and carry out discarded
`default_nettype none

module cla_adder (
  input  wire mul16_pkg::product_t  a,
  input  wire mul16_pkg::product_t  b,
  output mul16_pkg::product_t       sum
);

  mul16_pkg::product_t bit_p;
  mul16_pkg::product_t bit_g;
  mul16_pkg::product_t bit_carry;

  logic [mul16_pkg::PRODUCT_WIDTH/mul16_pkg::CLA_GROUP_WIDTH-1:0] group_p;
  logic [mul16_pkg::PRODUCT_WIDTH/mul16_pkg::CLA_GROUP_WIDTH-1:0] group_g;
  logic [mul16_pkg::PRODUCT_WIDTH/mul16_pkg::CLA_GROUP_WIDTH-1:0] group_carry;

  assign bit_p = a ^ b;
  assign bit_g = a & b;

  // Group propagate and generate over each 4-bit group
  always_comb begin : group_pg
    int base;
    for (int k = 0; k < mul16_pkg::PRODUCT_WIDTH / mul16_pkg::CLA_GROUP_WIDTH; k++) begin
      base = k * mul16_pkg::CLA_GROUP_WIDTH;
      group_p[k] = &bit_p[base +: mul16_pkg::CLA_GROUP_WIDTH];
      group_g[k] = bit_g[base+3]
                 | (bit_p[base+3] & bit_g[base+2])
                 | (bit_p[base+3] & bit_p[base+2] & bit_g[base+1])
                 | (bit_p[base+3] & bit_p[base+2] & bit_p[base+1] & bit_g[base]);
    end
  end

  // Second level, flattened so no carry ripples between groups
  always_comb begin : lookahead
    logic term;
    group_carry[0] = 1'b0;
    for (int k = 1; k < mul16_pkg::PRODUCT_WIDTH / mul16_pkg::CLA_GROUP_WIDTH; k++) begin
      group_carry[k] = 1'b0;
      // A lower group generates and every group above it up to k propagates
      for (int m = 0; m < k; m++) begin
        term = group_g[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & group_p[n];
        end
        group_carry[k] = group_carry[k] | term;
      end
    end
  end

  // Carries inside each group from its incoming group carry
  always_comb begin : group_carries
    int base;
    for (int k = 0; k < mul16_pkg::PRODUCT_WIDTH / mul16_pkg::CLA_GROUP_WIDTH; k++) begin
      base = k * mul16_pkg::CLA_GROUP_WIDTH;
      bit_carry[base]   = group_carry[k];
      bit_carry[base+1] = bit_g[base] | (bit_p[base] & group_carry[k]);
      bit_carry[base+2] = bit_g[base+1]
                        | (bit_p[base+1] & bit_g[base])
                        | (bit_p[base+1] & bit_p[base] & group_carry[k]);
      bit_carry[base+3] = bit_g[base+2]
                        | (bit_p[base+2] & bit_g[base+1])
                        | (bit_p[base+2] & bit_p[base+1] & bit_g[base])
                        | (bit_p[base+2] & bit_p[base+1] & bit_p[base] & group_carry[k]);
    end
  end

  assign sum = bit_p ^ bit_carry;

endmodule

`default_nettype wire

/* verilog/mul16_pipe.sv */
// 16x16 unsigned multiplier, two-stage valid/ready pipeline, two cycles latency without stalls
`default_nettype none

module mul16_pipe (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire mul16_pkg::operand_t  a,
  input  wire mul16_pkg::operand_t  b,
  output logic                      out_valid,
  input  wire                       out_ready,
  output mul16_pkg::product_t       product
);

  logic pp_valid;
  logic pp_ready;

  mul16_pkg::half_product_t pp_ll;
  mul16_pkg::half_product_t pp_lh;
  mul16_pkg::half_product_t pp_hl;
  mul16_pkg::half_product_t pp_hh;

  partial_product_stage u_pp_stage (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .a        (a),
    .b        (b),
    .pp_valid (pp_valid),
    .pp_ready (pp_ready),
    .pp_ll    (pp_ll),
    .pp_lh    (pp_lh),
    .pp_hl    (pp_hl),
    .pp_hh    (pp_hh)
  );

  reduction_stage u_red_stage (
    .clk       (clk),
    .reset     (reset),
    .pp_valid  (pp_valid),
    .pp_ready  (pp_ready),
    .pp_ll     (pp_ll),
    .pp_lh     (pp_lh),
    .pp_hl     (pp_hl),
    .pp_hh     (pp_hh),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .product   (product)
  );

endmodule

`default_nettype wire

/* verilog/mul16_pkg.sv */
// Shared widths and vector types; the design is fixed at 16-bit unsigned operands split in 8-bit halves
`default_nettype none

package mul16_pkg;

  // Operand half and the full operand
  localparam int HALF_WIDTH = 8;
  localparam int OPERAND_WIDTH = 2 * HALF_WIDTH;

  // Full product
  localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

  // Bits per lookahead group in the adders
  localparam int CLA_GROUP_WIDTH = 4;

  // One 8-bit operand half
  typedef logic [HALF_WIDTH-1:0] half_t;

  // One 16-bit operand
  typedef logic [OPERAND_WIDTH-1:0] operand_t;

  // Product of two halves
  typedef logic [OPERAND_WIDTH-1:0] half_product_t;

  // Full product, also used for aligned partial sums
  typedef logic [PRODUCT_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

/* verilog/mul8_array.sv */
// Exact unsigned 8x8 array multiplier, purely combinational, no carry out beyond the 16 product bits
`default_nettype none

module mul8_array (
  input  wire mul16_pkg::half_t     a,
  input  wire mul16_pkg::half_t     b,
  output mul16_pkg::half_product_t  product
);

  // pp[i][j] is a[j] & b[i]
  mul16_pkg::half_t pp [mul16_pkg::HALF_WIDTH];

  // Sum and carry of adder rows 1 to 7, one cell per column
  logic [mul16_pkg::HALF_WIDTH-2:0] row_sum   [1:mul16_pkg::HALF_WIDTH-1];
  logic [mul16_pkg::HALF_WIDTH-2:0] row_carry [1:mul16_pkg::HALF_WIDTH-1];

  // Bits entering a row from the row above, shifted one column
  logic [mul16_pkg::HALF_WIDTH-2:0] row_top   [2:mul16_pkg::HALF_WIDTH];

  logic [mul16_pkg::HALF_WIDTH-1:0] ripple_carry;

  function automatic logic fa_sum(input logic x, input logic y, input logic z);
    return x ^ y ^ z;
  endfunction

  function automatic logic fa_carry(input logic x, input logic y, input logic z);
    return (x & y) | (z & (x ^ y));
  endfunction

  always_comb begin
    for (int i = 0; i < mul16_pkg::HALF_WIDTH; i++) begin
      pp[i] = a & {mul16_pkg::HALF_WIDTH{b[i]}};
    end
  end

  always_comb begin
    // Row 1 is a row of half adders
    for (int j = 0; j < mul16_pkg::HALF_WIDTH - 1; j++) begin
      row_sum[1][j]   = pp[0][j+1] ^ pp[1][j];
      row_carry[1][j] = pp[0][j+1] & pp[1][j];
    end

    // Carry-save full adder rows
    for (int i = 2; i < mul16_pkg::HALF_WIDTH; i++) begin
      row_top[i] = {pp[i-1][mul16_pkg::HALF_WIDTH-1],
                    row_sum[i-1][mul16_pkg::HALF_WIDTH-2:1]};
      for (int j = 0; j < mul16_pkg::HALF_WIDTH - 1; j++) begin
        row_sum[i][j]   = fa_sum(row_top[i][j], pp[i][j], row_carry[i-1][j]);
        row_carry[i][j] = fa_carry(row_top[i][j], pp[i][j], row_carry[i-1][j]);
      end
    end

    // Low product bits drop out of column 0 of each row
    product[0] = pp[0][0];
    for (int i = 1; i < mul16_pkg::HALF_WIDTH; i++) begin
      product[i] = row_sum[i][0];
    end

    // Final ripple row merges the last sums and carries
    row_top[mul16_pkg::HALF_WIDTH] = {pp[mul16_pkg::HALF_WIDTH-1][mul16_pkg::HALF_WIDTH-1],
                                      row_sum[mul16_pkg::HALF_WIDTH-1][mul16_pkg::HALF_WIDTH-2:1]};
    ripple_carry[0] = 1'b0;
    for (int j = 0; j < mul16_pkg::HALF_WIDTH - 1; j++) begin
      product[mul16_pkg::HALF_WIDTH+j] = fa_sum(row_top[mul16_pkg::HALF_WIDTH][j],
                                                row_carry[mul16_pkg::HALF_WIDTH-1][j],
                                                ripple_carry[j]);
      ripple_carry[j+1] = fa_carry(row_top[mul16_pkg::HALF_WIDTH][j],
                                   row_carry[mul16_pkg::HALF_WIDTH-1][j],
                                   ripple_carry[j]);
    end
    product[2*mul16_pkg::HALF_WIDTH-1] = ripple_carry[mul16_pkg::HALF_WIDTH-1];
  end

endmodule

`default_nettype wire

/* verilog/partial_product_stage.sv */
// Pipeline stage 1 with a single entry; a and b must stay stable while in_valid waits for in_ready
`default_nettype none

module partial_product_stage (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire mul16_pkg::operand_t  a,
  input  wire mul16_pkg::operand_t  b,
  output logic                      pp_valid,
  input  wire                       pp_ready,
  output mul16_pkg::half_product_t  pp_ll,
  output mul16_pkg::half_product_t  pp_lh,
  output mul16_pkg::half_product_t  pp_hl,
  output mul16_pkg::half_product_t  pp_hh
);

  mul16_pkg::half_t a_lo;
  mul16_pkg::half_t a_hi;
  mul16_pkg::half_t b_lo;
  mul16_pkg::half_t b_hi;

  mul16_pkg::half_product_t ll_next;
  mul16_pkg::half_product_t lh_next;
  mul16_pkg::half_product_t hl_next;
  mul16_pkg::half_product_t hh_next;

  assign a_lo = a[mul16_pkg::HALF_WIDTH-1:0];
  assign a_hi = a[mul16_pkg::OPERAND_WIDTH-1:mul16_pkg::HALF_WIDTH];
  assign b_lo = b[mul16_pkg::HALF_WIDTH-1:0];
  assign b_hi = b[mul16_pkg::OPERAND_WIDTH-1:mul16_pkg::HALF_WIDTH];

  mul8_array u_mul_ll (.a(a_lo), .b(b_lo), .product(ll_next));
  mul8_array u_mul_lh (.a(a_lo), .b(b_hi), .product(lh_next));
  mul8_array u_mul_hl (.a(a_hi), .b(b_lo), .product(hl_next));
  mul8_array u_mul_hh (.a(a_hi), .b(b_hi), .product(hh_next));

  // Free when empty or when the held entry leaves this cycle
  assign in_ready = !pp_valid || pp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pp_valid <= 1'b0;
    end else if (in_ready) begin
      pp_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      pp_ll <= ll_next;
      pp_lh <= lh_next;
      pp_hl <= hl_next;
      pp_hh <= hh_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/reduction_stage.sv */
// Pipeline stage 2 with a single entry; product holds while out_valid is high and out_ready low
`default_nettype none

module reduction_stage (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       pp_valid,
  output logic                      pp_ready,
  input  wire mul16_pkg::half_product_t pp_ll,
  input  wire mul16_pkg::half_product_t pp_lh,
  input  wire mul16_pkg::half_product_t pp_hl,
  input  wire mul16_pkg::half_product_t pp_hh,
  output logic                      out_valid,
  input  wire                       out_ready,
  output mul16_pkg::product_t       product
);

  mul16_pkg::product_t hh_ll_word;
  mul16_pkg::product_t lh_word;
  mul16_pkg::product_t hl_word;
  mul16_pkg::product_t partial_sum;
  mul16_pkg::product_t product_next;

  // High and low products do not overlap, so they share one word
  assign hh_ll_word = {pp_hh, pp_ll};

  // Cross products sit one half up
  assign lh_word = {{mul16_pkg::HALF_WIDTH{1'b0}}, pp_lh, {mul16_pkg::HALF_WIDTH{1'b0}}};
  assign hl_word = {{mul16_pkg::HALF_WIDTH{1'b0}}, pp_hl, {mul16_pkg::HALF_WIDTH{1'b0}}};

  cla_adder u_add_first (
    .a   (hh_ll_word),
    .b   (lh_word),
    .sum (partial_sum)
  );

  cla_adder u_add_second (
    .a   (partial_sum),
    .b   (hl_word),
    .sum (product_next)
  );

  assign pp_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (pp_ready) begin
      out_valid <= pp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pp_valid && pp_ready) begin
      product <= product_next;
    end
  end

endmodule

`default_nettype wire
